// ==== wb_conmax_master_if.f ====
rtl/wb_bus_pkg.sv
rtl/conmax_map_pkg.sv
rtl/conmax_cyc_route.sv
rtl/conmax_resp_mux.sv
rtl/wb_conmax_master_if.sv
tests/wb_conmax_master_if_checker.sv
tests/tb_wb_conmax_master_if.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the Wishbone master port testbench with Verilator and run it.
# Exit status is zero only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_wb_conmax_master_if
FILE_LIST=wb_conmax_master_if.f
BUILD_DIR=obj_dir
LOG_FILE=sim.log

# Compile and build the simulation binary
verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-f "$FILE_LIST"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

if [ ! -x "$BUILD_DIR/V$TOP" ]; then
	echo "Simulation binary $BUILD_DIR/V$TOP is missing"
	exit 1
fi

# Run the simulation and keep its output
"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The verdict comes from the log
if grep -qx "TEST PASS" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG_FILE"
	exit 1
fi

// ==== tests/tb_wb_conmax_master_if.sv ====
`timescale 1ns/100ps

module tb_wb_conmax_master_if
	import wb_bus_pkg::*;
	import conmax_map_pkg::*;
();

	localparam int NUM_SLAVES     = CONMAX_SLAVES;
	localparam int CLK_PERIOD     = 8;
	localparam int RST_CYCLES     = 8;
	// One idle row, then request, gap and drop per slave
	localparam int NUM_ROWS       = 1 + 3 * NUM_SLAVES;
	localparam int TIMEOUT_CYCLES = 2 * NUM_ROWS + RST_CYCLES + 20;

	typedef logic [NUM_SLAVES-1:0] slv_vec_t;

	// Master request and slave terminations for one clock
	typedef struct packed {
		wb_addr_t addr;
		wb_data_t wdata;
		wb_sel_t  sel;
		logic     we;
		logic     cyc;
		logic     stb;
		slv_vec_t ack;
		slv_vec_t err;
		slv_vec_t rty;
	} row_t;

	// Expected slave lines and master return for one row
	typedef struct packed {
		slv_vec_t stb;
		slv_vec_t cyc;
		wb_data_t data;
		logic     ack;
		logic     err;
		logic     rty;
	} expect_t;

	logic                      clk_i;
	logic                      rst_i;
	wb_addr_t                  wb_addr_i;
	wb_data_t                  wb_data_i;
	wb_sel_t                   wb_sel_i;
	logic                      wb_we_i;
	logic                      wb_cyc_i;
	logic                      wb_stb_i;
	wb_data_t                  wb_data_o;
	logic                      wb_ack_o;
	logic                      wb_err_o;
	logic                      wb_rty_o;
	wb_addr_t                  s_addr_o;
	wb_data_t                  s_data_o;
	wb_sel_t                   s_sel_o;
	logic                      s_we_o;
	slv_vec_t                  s_cyc_o;
	slv_vec_t                  s_stb_o;
	wb_data_t [NUM_SLAVES-1:0] s_data_i;
	slv_vec_t                  s_ack_i;
	slv_vec_t                  s_err_i;
	slv_vec_t                  s_rty_i;

	wb_data_t slave_word [NUM_SLAVES];
	row_t     rows       [NUM_ROWS];
	expect_t  expects    [NUM_ROWS];
	int       cur_row;
	int       cycle_count = 0;

	wb_conmax_master_if #(
		.NUM_SLAVES (NUM_SLAVES)
	) uut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wb_addr_i (wb_addr_i),
		.wb_data_i (wb_data_i),
		.wb_sel_i  (wb_sel_i),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_data_o (wb_data_o),
		.wb_ack_o  (wb_ack_o),
		.wb_err_o  (wb_err_o),
		.wb_rty_o  (wb_rty_o),
		.s_addr_o  (s_addr_o),
		.s_data_o  (s_data_o),
		.s_sel_o   (s_sel_o),
		.s_we_o    (s_we_o),
		.s_cyc_o   (s_cyc_o),
		.s_stb_o   (s_stb_o),
		.s_data_i  (s_data_i),
		.s_ack_i   (s_ack_i),
		.s_err_i   (s_err_i),
		.s_rty_i   (s_rty_i)
	);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// Run limit
	always @(posedge clk_i) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s at row %0d: got %h, expected %h", name, cur_row, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Random request aimed at one slave, bus idle
	function automatic row_t random_row(input int slv);
		row_t row;
		row.addr                         = wb_addr_t'($urandom);
		row.addr[WB_AW-1 -: SLV_SEL_W]   = slv_idx_t'(slv);
		row.wdata                        = wb_data_t'($urandom);
		row.sel                          = wb_sel_t'($urandom);
		row.we                           = 1'($urandom);
		row.cyc                          = 1'b0;
		row.stb                          = 1'b0;
		row.ack                          = slv_vec_t'($urandom);
		row.err                          = slv_vec_t'($urandom);
		row.rty                          = slv_vec_t'($urandom);
		return row;
	endfunction

	task automatic build_table();
		row_t     row;
		slv_vec_t onehot;
		rows[0] = random_row(0);
		for (int k = 0; k < NUM_SLAVES; k++) begin
			onehot    = '0;
			onehot[k] = 1'b1;
			// Request, the addressed flags differ from all the others
			row       = random_row(k);
			row.cyc   = 1'b1;
			row.stb   = 1'b1;
			row.ack   = (k % 2 == 1) ? ~onehot : onehot;
			row.err   = ~row.ack;
			rows[1 + 3 * k] = row;
			// Gap inside the cycle while the address moves away
			row       = random_row((k + 5) % NUM_SLAVES);
			row.cyc   = 1'b1;
			row.ack   = onehot;
			row.err   = ~onehot;
			rows[2 + 3 * k] = row;
			// End of cycle
			rows[3 + 3 * k] = random_row((k + 9) % NUM_SLAVES);
		end
	endtask

	// Expected values straight from the routing rules
	task automatic derive_expected();
		slv_vec_t cyc_prev;
		slv_vec_t hit;
		slv_idx_t slv;
		cyc_prev = '0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			slv      = rows[r].addr[WB_AW-1 -: SLV_SEL_W];
			hit      = '0;
			hit[slv] = 1'b1;
			expects[r].stb = rows[r].stb ? hit : '0;
			if (rows[r].cyc && !rows[r].stb) begin
				expects[r].cyc = cyc_prev;
			end else begin
				expects[r].cyc = rows[r].cyc ? hit : '0;
			end
			cyc_prev        = expects[r].cyc;
			expects[r].data = slave_word[slv];
			expects[r].ack  = rows[r].ack[slv];
			expects[r].err  = rows[r].err[slv];
			expects[r].rty  = rows[r].rty[slv];
		end
	endtask

	task automatic drive_row(input row_t row);
		wb_addr_i = row.addr;
		wb_data_i = row.wdata;
		wb_sel_i  = row.sel;
		wb_we_i   = row.we;
		wb_cyc_i  = row.cyc;
		wb_stb_i  = row.stb;
		s_ack_i   = row.ack;
		s_err_i   = row.err;
		s_rty_i   = row.rty;
	endtask

	// Everything that settles without a clock edge
	task automatic check_outputs(input row_t row, input expect_t exp);
		check_value("s_stb_o", 32'(s_stb_o), 32'(exp.stb));
		check_value("s_addr_o", 32'(s_addr_o), 32'(row.addr));
		check_value("s_data_o", 32'(s_data_o), 32'(row.wdata));
		check_value("s_sel_o", 32'(s_sel_o), 32'(row.sel));
		check_value("s_we_o", 32'(s_we_o), 32'(row.we));
		check_value("wb_data_o", 32'(wb_data_o), 32'(exp.data));
		check_value("wb_ack_o", 32'(wb_ack_o), 32'(exp.ack));
		check_value("wb_err_o", 32'(wb_err_o), 32'(exp.err));
		check_value("wb_rty_o", 32'(wb_rty_o), 32'(exp.rty));
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		void'($urandom(32'hfb74));
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		wb_addr_i = '0;
		wb_data_i = '0;
		wb_sel_i  = '0;
		wb_we_i   = 1'b0;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		s_ack_i   = '0;
		s_err_i   = '0;
		s_rty_i   = '0;
		cur_row   = -1;

		// Slave read words stay fixed for the run
		for (int k = 0; k < NUM_SLAVES; k++) begin
			slave_word[k] = wb_data_t'($urandom);
			s_data_i[k]   = slave_word[k];
		end

		build_table();
		derive_expected();

		repeat (RST_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;
		check_value("s_cyc_o", 32'(s_cyc_o), 32'h0);
		check_value("s_stb_o", 32'(s_stb_o), 32'h0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			slv_vec_t cyc_reg;
			cyc_reg = (r > 0) ? expects[r - 1].cyc : '0;
			@(negedge clk_i);
			// Cycle lines registered at the edge that closed the last row
			check_value("s_cyc_o", 32'(s_cyc_o), 32'(cyc_reg));
			cur_row = r;
			drive_row(rows[r]);
			#1;
			check_outputs(rows[r], expects[r]);
			// New request has not met a clock edge yet
			check_value("s_cyc_o", 32'(s_cyc_o), 32'(cyc_reg));
		end

		@(negedge clk_i);
		check_value("s_cyc_o", 32'(s_cyc_o), 32'(expects[NUM_ROWS - 1].cyc));

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== tests/wb_conmax_master_if_checker.sv ====
`timescale 1ns/100ps

module wb_conmax_master_if_checker #(
	parameter int NUM_SLAVES = 16
) (
	input logic                  clk_i,
	input logic                  rst_i,
	input logic                  wb_stb_i,
	input logic [NUM_SLAVES-1:0] s_cyc_i,
	input logic [NUM_SLAVES-1:0] s_stb_i
);

	////////////////////
	// Slave handshake
	////////////////////

	// Strobe reaches one slave at most
	a_stb_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(s_stb_i))
		else $error("More than one slave strobe is high");

	// Only one slave owns the cycle
	a_cyc_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(s_cyc_i))
		else $error("More than one slave cycle line is high");

	// No slave strobe without a master strobe
	a_stb_source: assert property (@(posedge clk_i) disable iff (rst_i)
		(|s_stb_i) |-> wb_stb_i)
		else $error("Slave strobe high while master strobe is low");

	// Cycle lines still clear on the first edge out of reset
	a_cyc_reset: assert property (@(posedge clk_i)
		$fell(rst_i) |-> (s_cyc_i == '0))
		else $error("Slave cycle lines not clear after reset");

endmodule

bind wb_conmax_master_if wb_conmax_master_if_checker #(
	.NUM_SLAVES (NUM_SLAVES)
) u_checker (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.wb_stb_i (wb_stb_i),
	.s_cyc_i  (s_cyc_o),
	.s_stb_i  (s_stb_o)
);

// ==== rtl/wb_conmax_master_if.sv ====
`timescale 1ns/100ps

module wb_conmax_master_if
	import wb_bus_pkg::*;
	import conmax_map_pkg::*;
#(
	parameter int NUM_SLAVES = CONMAX_SLAVES,
	parameter int DW         = WB_DW,
	parameter int AW         = WB_AW
) (
	input  logic                      clk_i,
	input  logic                      rst_i,

	// Master request
	input  wb_addr_t                  wb_addr_i,
	input  wb_data_t                  wb_data_i,
	input  wb_sel_t                   wb_sel_i,
	input  logic                      wb_we_i,
	input  logic                      wb_cyc_i,
	input  logic                      wb_stb_i,

	// Master return
	output wb_data_t                  wb_data_o,
	output logic                      wb_ack_o,
	output logic                      wb_err_o,
	output logic                      wb_rty_o,

	// Shared request seen by every slave
	output wb_addr_t                  s_addr_o,
	output wb_data_t                  s_data_o,
	output wb_sel_t                   s_sel_o,
	output logic                      s_we_o,

	// Per-slave handshake
	output logic     [NUM_SLAVES-1:0] s_cyc_o,
	output logic     [NUM_SLAVES-1:0] s_stb_o,

	// Per-slave returns
	input  wb_data_t [NUM_SLAVES-1:0] s_data_i,
	input  logic     [NUM_SLAVES-1:0] s_ack_i,
	input  logic     [NUM_SLAVES-1:0] s_err_i,
	input  logic     [NUM_SLAVES-1:0] s_rty_i
);

	////////////////////
	// Slave select
	////////////////////

	slv_idx_t slv_sel;

	// Top address bits name the slave
	assign slv_sel = wb_addr_i[AW-1 -: SLV_SEL_W];

	////////////////////
	// Broadcast path
	////////////////////

	// Same request on every slave, only cyc and stb qualify it
	assign s_addr_o = wb_addr_i;
	assign s_data_o = wb_data_i;
	assign s_sel_o  = wb_sel_i;
	assign s_we_o   = wb_we_i;

	////////////////////
	// Cycle and strobe
	////////////////////

	conmax_cyc_route #(
		.NUM_SLAVES (NUM_SLAVES)
	) u_cyc_route (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.slv_sel_i (slv_sel),
		.cyc_i     (wb_cyc_i),
		.stb_i     (wb_stb_i),
		.cyc_o     (s_cyc_o),
		.stb_o     (s_stb_o)
	);

	////////////////////
	// Return path
	////////////////////

	conmax_resp_mux #(
		.NUM_SLAVES (NUM_SLAVES)
	) u_resp_mux (
		.slv_sel_i (slv_sel),
		.s_data_i  (s_data_i),
		.s_ack_i   (s_ack_i),
		.s_err_i   (s_err_i),
		.s_rty_i   (s_rty_i),
		.data_o    (wb_data_o),
		.ack_o     (wb_ack_o),
		.err_o     (wb_err_o),
		.rty_o     (wb_rty_o)
	);

	////////////////////
	// Build checks
	////////////////////

	// Port types come from the bus package, so the widths must agree
	if (DW != $bits(wb_data_t)) begin : g_bad_dw
		$error("wb_conmax_master_if: DW %0d differs from bus data width", DW);
	end

	if (AW != $bits(wb_addr_t)) begin : g_bad_aw
		$error("wb_conmax_master_if: AW %0d differs from bus address width", AW);
	end

	// Power of two from 2 up to the select field range
	if ((NUM_SLAVES < 2) || (NUM_SLAVES > (1 << SLV_SEL_W)) ||
		((NUM_SLAVES & (NUM_SLAVES - 1)) != 0)) begin : g_bad_count
		$error("wb_conmax_master_if: unsupported NUM_SLAVES %0d", NUM_SLAVES);
	end

endmodule

// ==== rtl/conmax_resp_mux.sv ====
`timescale 1ns/100ps

module conmax_resp_mux
	import wb_bus_pkg::*;
	import conmax_map_pkg::*;
#(
	parameter int NUM_SLAVES = 16
) (
	// Decoded slave number
	input  slv_idx_t                  slv_sel_i,

	// Returns from every slave
	input  wb_data_t [NUM_SLAVES-1:0] s_data_i,
	input  logic     [NUM_SLAVES-1:0] s_ack_i,
	input  logic     [NUM_SLAVES-1:0] s_err_i,
	input  logic     [NUM_SLAVES-1:0] s_rty_i,

	// Return to the master
	output wb_data_t                  data_o,
	output logic                      ack_o,
	output logic                      err_o,
	output logic                      rty_o
);

	////////////////////
	// Slave hit vector
	////////////////////

	// One-hot, all zero when the index lies past the last slave
	logic [NUM_SLAVES-1:0] hit;

	for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_hit
		assign hit[k] = (slv_sel_i == slv_idx_t'(k));
	end

	////////////////////
	// Termination flags
	////////////////////

	// AND-OR select, no slave hit gives all flags low
	assign ack_o = |(s_ack_i & hit);
	assign err_o = |(s_err_i & hit);
	assign rty_o = |(s_rty_i & hit);

	////////////////////
	// Read data
	////////////////////

	// Out-of-range index reads back zero
	always_comb begin
		data_o = '0;
		for (int k = 0; k < NUM_SLAVES; k++) begin
			if (hit[k]) begin
				data_o = s_data_i[k];
			end
		end
	end

	////////////////////
	// Build checks
	////////////////////

	if (NUM_SLAVES > (1 << SLV_SEL_W)) begin : g_bad_count
		$error("conmax_resp_mux: NUM_SLAVES %0d exceeds select field", NUM_SLAVES);
	end

endmodule

// ==== rtl/conmax_cyc_route.sv ====
`timescale 1ns/100ps

module conmax_cyc_route
	import conmax_map_pkg::*;
#(
	parameter int NUM_SLAVES = 16
) (
	input  logic                  clk_i,
	input  logic                  rst_i,

	// Decoded slave number and master handshake
	input  slv_idx_t              slv_sel_i,
	input  logic                  cyc_i,
	input  logic                  stb_i,

	// Per-slave cycle and strobe lines
	output logic [NUM_SLAVES-1:0] cyc_o,
	output logic [NUM_SLAVES-1:0] stb_o
);

	////////////////////
	// Shared terms
	////////////////////

	// Master inside a cycle but between strobes
	logic hold;

	assign hold = cyc_i & ~stb_i;

	////////////////////
	// Per-slave slots
	////////////////////

	for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slot
		// Address points at this slave
		logic hit;
		// Next cycle value and the registered line
		logic cyc_d;
		logic cyc_q;

		assign hit = (slv_sel_i == slv_idx_t'(k));

		// Idle gap inside a cycle keeps the slave owned,
		// otherwise the line follows cyc for the addressed slave
		assign cyc_d = hold ? cyc_q : (hit & cyc_i);

		always_ff @(posedge clk_i or posedge rst_i) begin
			if (rst_i) begin
				cyc_q <= 1'b0;
			end else begin
				cyc_q <= cyc_d;
			end
		end

		assign cyc_o[k] = cyc_q;

		// Strobe is steered with no delay
		assign stb_o[k] = hit & stb_i;
	end

	////////////////////
	// Build checks
	////////////////////

	// Index must be wide enough to reach every slot
	if (NUM_SLAVES > (1 << SLV_SEL_W)) begin : g_bad_count
		$error("conmax_cyc_route: NUM_SLAVES %0d exceeds select field", NUM_SLAVES);
	end

endmodule

// ==== rtl/conmax_map_pkg.sv ====
package conmax_map_pkg;

	////////////////////
	// Slave map
	////////////////////

	// Slave ports behind one master port
	localparam int CONMAX_SLAVES = 16;

	// Address bits that select the slave, taken from the top of the address
	localparam int SLV_SEL_W = 4;

	////////////////////
	// Index type
	////////////////////

	// Slave number as decoded from the address
	typedef logic [SLV_SEL_W-1:0] slv_idx_t;

endpackage

// ==== rtl/wb_bus_pkg.sv ====
package wb_bus_pkg;

	////////////////////
	// Bus widths
	////////////////////

	// Data path width in bits
	localparam int WB_DW = 32;

	// Byte address width in bits
	localparam int WB_AW = 32;

	////////////////////
	// Bus vector types
	////////////////////

	// One data word as it travels on the bus
	typedef logic [WB_DW-1:0] wb_data_t;

	// Byte address, top bits also pick the slave
	typedef logic [WB_AW-1:0] wb_addr_t;

	// Byte lane enables, one per eight data bits
	typedef logic [WB_DW/8-1:0] wb_sel_t;

endpackage
